// ==== design/fpCtrlPkg.sv ====
`default_nettype none

package fpCtrlPkg;

    // Instruction field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 26;
    localparam int FMT_HI    = 24;
    localparam int FMT_LO    = 21;
    localparam int FUNC_HI   = 5;
    localparam int FUNC_LO   = 0;

    localparam logic [5:0] COP1 = 6'h11;  // FP opcode

    // Function codes
    localparam logic [5:0] FN_ADD  = 6'h00;
    localparam logic [5:0] FN_SUB  = 6'h01;
    localparam logic [5:0] FN_MUL  = 6'h02;
    localparam logic [5:0] FN_DIV  = 6'h03;
    localparam logic [5:0] FN_ABS  = 6'h05;
    localparam logic [5:0] FN_MOV  = 6'h06;
    localparam logic [5:0] FN_NEG  = 6'h07;
    localparam logic [5:0] FN_CVTS = 6'h20;
    localparam logic [5:0] FN_CVTD = 6'h21;
    localparam logic [5:0] FN_CVTW = 6'h24;
    localparam logic [1:0] FN_CMP_HI = 2'b11;  // Bits 5:4 of any compare

    // Format codes
    localparam logic [3:0] FMT_SINGLE = 4'h0;
    localparam logic [3:0] FMT_DOUBLE = 4'h1;
    localparam logic [3:0] FMT_FIXED  = 4'h4;

    typedef enum logic [2:0] {
        NONE,
        MOV,
        ABS,
        NEG,
        CMP,
        ARITH,   // Add, sub, mul, div handled off this block
        UNIM
    } fpOp_t;

    // Bit 5 unimplemented, then invalid, divZero, overflow, underflow, inexact
    typedef logic [5:0] fpExc_t;

    localparam int EXC_UNIM = 5;
    localparam int EXC_INV  = 4;

    // CSR layout
    localparam int CSR_FLAGS_LO = 2;
    localparam int CSR_FLAGS_HI = 6;
    localparam int CSR_EN_LO    = 7;
    localparam int CSR_EN_HI    = 11;
    localparam int CSR_CAUSE_LO = 12;
    localparam int CSR_CAUSE_HI = 17;
    localparam int CSR_COND     = 23;

    typedef struct packed {
        logic [63:0] result;
        fpExc_t      exc;
        logic        cond;
    } exPayload_t;

    typedef struct packed {
        logic [63:0] result;
        fpExc_t      exc;
        logic        cond;
    } memPayload_t;

endpackage

`default_nettype wire

// ==== design/fpStageReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpStageReg #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     phi1,
    input  wire logic     arstN,
    input  wire logic     stall,
    input  wire logic     validIn,
    input  wire payload_t dataIn,
    output logic          validOut,
    output payload_t      dataOut
);

    always_ff @(posedge phi1 or negedge arstN) begin
        if (!arstN) begin
            validOut <= 1'b0;
        end else if (!stall) begin
            validOut <= validIn;
        end
    end

    // Payload is qualified by validOut
    always_ff @(posedge phi1) begin
        if (!stall) begin
            dataOut <= dataIn;
        end
    end

    holdOnStall: assert property (@(posedge phi1) disable iff (!arstN)
        stall |=> $stable(validOut));

endmodule

`default_nettype wire

// ==== design/fpDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpDecode import fpCtrlPkg::*; (
    input  wire logic        phi1,
    input  wire logic        arstN,
    input  wire logic        stall,
    input  wire logic [31:0] instr,
    input  wire logic        instrValid,
    input  wire logic [63:0] opAIn,
    input  wire logic [63:0] opBIn,
    output fpOp_t            opClass,
    output logic [3:0]       cmpCond,
    output logic             opIsAdd,
    output logic             opIsSub,
    output logic             opIsMul,
    output logic             opIsDiv,
    output logic             opIsAbs,
    output logic             opIsMov,
    output logic             opIsNeg,
    output logic             opIsCmp,
    output logic             fmtSingle,
    output logic             fmtDouble,
    output logic             fmtFixed,
    output logic             exValid,
    output logic [63:0]      opA,
    output logic [63:0]      opB
);

    logic       accept;
    logic [5:0] func;
    logic [3:0] fmt;
    logic       isCmp;
    logic       fmtKnown;
    fpOp_t      classNext;

    assign func     = instr[FUNC_HI:FUNC_LO];
    assign fmt      = instr[FMT_HI:FMT_LO];
    assign accept   = instrValid && (instr[OPCODE_HI:OPCODE_LO] == COP1);
    assign isCmp    = (func[5:4] == FN_CMP_HI);
    assign fmtKnown = (fmt == FMT_SINGLE) || (fmt == FMT_DOUBLE) || (fmt == FMT_FIXED);

    always_comb begin
        if (isCmp) begin
            classNext = CMP;
        end else begin
            case (func)
                FN_ADD, FN_SUB, FN_MUL, FN_DIV: classNext = ARITH;
                FN_ABS: classNext = ABS;
                FN_MOV: classNext = MOV;
                FN_NEG: classNext = NEG;
                default: classNext = UNIM;  // Converts and unknown codes
            endcase
        end
        if (!fmtKnown) begin
            classNext = UNIM;
        end
    end

    // Control flops
    always_ff @(posedge phi1 or negedge arstN) begin
        if (!arstN) begin
            exValid   <= 1'b0;
            opClass   <= NONE;
            opIsAdd   <= 1'b0;
            opIsSub   <= 1'b0;
            opIsMul   <= 1'b0;
            opIsDiv   <= 1'b0;
            opIsAbs   <= 1'b0;
            opIsMov   <= 1'b0;
            opIsNeg   <= 1'b0;
            opIsCmp   <= 1'b0;
            fmtSingle <= 1'b0;
            fmtDouble <= 1'b0;
            fmtFixed  <= 1'b0;
        end else if (!stall) begin
            exValid   <= accept;
            opClass   <= accept ? classNext : NONE;
            opIsAdd   <= accept && (func == FN_ADD);
            opIsSub   <= accept && (func == FN_SUB);
            opIsMul   <= accept && (func == FN_MUL);
            opIsDiv   <= accept && (func == FN_DIV);
            opIsAbs   <= accept && (func == FN_ABS);
            opIsMov   <= accept && (func == FN_MOV);
            opIsNeg   <= accept && (func == FN_NEG);
            opIsCmp   <= accept && isCmp;
            fmtSingle <= accept && (fmt == FMT_SINGLE);
            fmtDouble <= accept && (fmt == FMT_DOUBLE);
            fmtFixed  <= accept && (fmt == FMT_FIXED);
        end
    end

    // Operands and compare condition
    always_ff @(posedge phi1) begin
        if (!stall) begin
            cmpCond <= func[3:0];
            opA     <= opAIn;
            opB     <= opBIn;
        end
    end

    onlyOneOp: assert property (@(posedge phi1) disable iff (!arstN)
        $onehot0({opIsAdd, opIsSub, opIsMul, opIsDiv, opIsAbs, opIsMov, opIsNeg, opIsCmp}));

endmodule

`default_nettype wire

// ==== design/fpExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpExecute import fpCtrlPkg::*; (
    input  wire logic        exValid,
    input  wire fpOp_t       opClass,
    input  wire logic [3:0]  cmpCond,
    input  wire logic        fmtDouble,
    input  wire logic [63:0] opA,
    input  wire logic [63:0] opB,
    output exPayload_t       exOut
);

    logic        signA;
    logic        signB;
    logic [62:0] magA;
    logic [62:0] magB;
    logic        nanA;
    logic        nanB;
    logic        unord;
    logic        eq;
    logic        lt;
    logic        cond;
    logic [63:0] srcA;
    logic [63:0] signMask;

    // Single sits in the low word of each operand
    always_comb begin
        if (fmtDouble) begin
            signA    = opA[63];
            signB    = opB[63];
            magA     = opA[62:0];
            magB     = opB[62:0];
            nanA     = (&opA[62:52]) && (|opA[51:0]);
            nanB     = (&opB[62:52]) && (|opB[51:0]);
            srcA     = opA;
            signMask = 64'h8000_0000_0000_0000;
        end else begin
            signA    = opA[31];
            signB    = opB[31];
            magA     = {32'b0, opA[30:0]};
            magB     = {32'b0, opB[30:0]};
            nanA     = (&opA[30:23]) && (|opA[22:0]);
            nanB     = (&opB[30:23]) && (|opB[22:0]);
            srcA     = {32'b0, opA[31:0]};
            signMask = 64'h0000_0000_8000_0000;
        end
    end

    // Sign-magnitude relation
    always_comb begin
        unord = nanA || nanB;
        eq    = 1'b0;
        lt    = 1'b0;
        if (!unord) begin
            if (magA == 63'd0 && magB == 63'd0) begin
                eq = 1'b1;  // +0 == -0
            end else if (signA != signB) begin
                lt = signA;
            end else if (magA == magB) begin
                eq = 1'b1;
            end else begin
                lt = signA ? (magA > magB) : (magA < magB);
            end
        end
        cond = |({lt, eq, unord} & cmpCond[2:0]);
    end

    always_comb begin
        exOut = '0;
        if (exValid) begin
            case (opClass)
                MOV: exOut.result = srcA;
                ABS: exOut.result = srcA & ~signMask;
                NEG: exOut.result = srcA ^ signMask;
                CMP: begin
                    exOut.cond          = cond;
                    exOut.exc[EXC_INV]  = unord && cmpCond[3];  // Signalling compare
                end
                ARITH, UNIM: exOut.exc[EXC_UNIM] = 1'b1;
                default: exOut = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/fpCsr.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpCsr import fpCtrlPkg::*; (
    input  wire logic        phi1,
    input  wire logic        arstN,
    input  wire logic        stall,
    input  wire logic        wbValid,
    input  wire fpExc_t      wbExc,
    input  wire logic        wbCond,
    input  wire logic        csrWe,
    input  wire logic [31:0] csrWrData,
    output logic             fpTrap,
    output logic [31:0]      csr
);

    logic        retire;
    logic [31:0] csrNext;
    logic [4:0]  enabledHits;

    assign retire      = wbValid && !stall;
    assign enabledHits = wbExc[EXC_INV:0] & csr[CSR_EN_HI:CSR_EN_LO];

    // Unimplemented always traps, the rest only when enabled
    assign fpTrap = retire && (wbExc[EXC_UNIM] || (|enabledHits));

    always_comb begin
        csrNext = csrWe ? csrWrData : csr;
        if (retire) begin
            csrNext[CSR_CAUSE_HI:CSR_CAUSE_LO] = wbExc;
            csrNext[CSR_FLAGS_HI:CSR_FLAGS_LO] =
                csrNext[CSR_FLAGS_HI:CSR_FLAGS_LO] | wbExc[EXC_INV:0];  // Sticky
            csrNext[CSR_COND] = wbCond;
        end
    end

    always_ff @(posedge phi1 or negedge arstN) begin
        if (!arstN) begin
            csr <= 32'b0;
        end else begin
            csr <= csrNext;
        end
    end

    trapNeedsValid: assert property (@(posedge phi1) disable iff (!arstN)
        fpTrap |-> wbValid);

endmodule

`default_nettype wire

// ==== design/fpCtrlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpCtrlUnit import fpCtrlPkg::*; (
    input  wire logic        phi1,
    input  wire logic        arstN,
    input  wire logic [31:0] instr,
    input  wire logic        instrValid,
    input  wire logic [63:0] opA,
    input  wire logic [63:0] opB,
    input  wire logic        stall,
    input  wire logic        csrWe,
    input  wire logic [31:0] csrWrData,
    output logic             instrIsFp,
    output logic             opIsAdd,
    output logic             opIsSub,
    output logic             opIsMul,
    output logic             opIsDiv,
    output logic             opIsAbs,
    output logic             opIsMov,
    output logic             opIsNeg,
    output logic             opIsCmp,
    output logic             fmtSingle,
    output logic             fmtDouble,
    output logic             fmtFixed,
    output logic             resultValid,
    output logic [63:0]      result,
    output fpExc_t           resultExc,
    output logic             fpCond,
    output logic             fpTrap,
    output logic [31:0]      csr
);

    fpOp_t       opClass;
    logic [3:0]  cmpCond;
    logic        exValid;
    logic [63:0] opAEx;
    logic [63:0] opBEx;
    exPayload_t  exOut;
    logic        memValid;
    exPayload_t  memData;
    logic        wbValid;
    memPayload_t wbData;

    // Goes to the register file
    assign instrIsFp = (instr[OPCODE_HI:OPCODE_LO] == COP1);

    assign resultValid = wbValid && !stall;  // Nothing retires while frozen
    assign result      = wbData.result;
    assign resultExc   = wbData.exc;
    assign fpCond      = wbData.cond;

    fpDecode fpDecode_inst (
        .phi1(phi1), .arstN(arstN), .stall(stall),
        .instr(instr), .instrValid(instrValid),
        .opAIn(opA), .opBIn(opB),
        .opClass(opClass), .cmpCond(cmpCond),
        .opIsAdd(opIsAdd), .opIsSub(opIsSub), .opIsMul(opIsMul), .opIsDiv(opIsDiv),
        .opIsAbs(opIsAbs), .opIsMov(opIsMov), .opIsNeg(opIsNeg), .opIsCmp(opIsCmp),
        .fmtSingle(fmtSingle), .fmtDouble(fmtDouble), .fmtFixed(fmtFixed),
        .exValid(exValid), .opA(opAEx), .opB(opBEx)
    );

    fpExecute fpExecute_inst (
        .exValid(exValid), .opClass(opClass), .cmpCond(cmpCond),
        .fmtDouble(fmtDouble), .opA(opAEx), .opB(opBEx),
        .exOut(exOut)
    );

    // EX to MEM
    fpStageReg #(.payload_t(exPayload_t)) memStage_inst (
        .phi1(phi1), .arstN(arstN), .stall(stall),
        .validIn(exValid), .dataIn(exOut),
        .validOut(memValid), .dataOut(memData)
    );

    // MEM to WB
    fpStageReg #(.payload_t(memPayload_t)) wbStage_inst (
        .phi1(phi1), .arstN(arstN), .stall(stall),
        .validIn(memValid), .dataIn(memData),
        .validOut(wbValid), .dataOut(wbData)
    );

    fpCsr fpCsr_inst (
        .phi1(phi1), .arstN(arstN), .stall(stall),
        .wbValid(wbValid), .wbExc(wbData.exc), .wbCond(wbData.cond),
        .csrWe(csrWe), .csrWrData(csrWrData),
        .fpTrap(fpTrap), .csr(csr)
    );

endmodule

`default_nettype wire

// ==== sim/fpCtrlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpCtrlUnitTb import fpCtrlPkg::*; ();

    localparam int CLK_PERIOD    = 4;
    localparam int TEST_CYCLES   = 700;  // Rough sum over all tests
    localparam int MARGIN_CYCLES = 200;

    logic        phi1;
    logic        arstN;
    logic [31:0] instr;
    logic        instrValid;
    logic [63:0] opA;
    logic [63:0] opB;
    logic        stall;
    logic        csrWe;
    logic [31:0] csrWrData;
    logic        instrIsFp;
    logic        opIsAdd;
    logic        opIsSub;
    logic        opIsMul;
    logic        opIsDiv;
    logic        opIsAbs;
    logic        opIsMov;
    logic        opIsNeg;
    logic        opIsCmp;
    logic        fmtSingle;
    logic        fmtDouble;
    logic        fmtFixed;
    logic        resultValid;
    logic [63:0] result;
    fpExc_t      resultExc;
    logic        fpCond;
    logic        fpTrap;
    logic [31:0] csr;

    int          seed = 32'h7fc478b1;
    int          trapCount = 0;
    int          cycleCount = 0;
    logic        checking;
    logic        latencyCheck;
    logic [31:0] csrModel;
    memPayload_t expQ[$];
    int          acceptQ[$];

    fpCtrlUnit fpCtrlUnit_inst (.*);

    always #(CLK_PERIOD / 2) phi1 = ~phi1;

    always @(posedge phi1) cycleCount <= cycleCount + 1;

    task automatic failNow();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic abortRun(input string msg);
        $display("ERROR: %s", msg);
        failNow();
    endtask

    task automatic checkWord(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            failNow();
        end
    endtask

    task automatic checkExc(input string name, input fpExc_t got, input fpExc_t want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            failNow();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            failNow();
        end
    endtask

    function automatic logic [31:0] mkInstr(input logic [5:0] func, input logic [3:0] fmt);
        return {COP1, 1'b1, fmt, 15'b0, func};
    endfunction

    function automatic logic [63:0] randWord();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic isNan(input logic [63:0] w, input logic dbl);
        if (dbl)
            return (w[62:52] == 11'h7ff) && (w[51:0] != '0);
        return (w[30:23] == 8'hff) && (w[22:0] != '0);
    endfunction

    // Maps sign-magnitude onto unsigned order with the sign in bit 63
    function automatic logic [63:0] orderKey(input logic [63:0] w);
        return w[63] ? ~w : (w | 64'h8000_0000_0000_0000);
    endfunction

    // Reference model of one instruction
    function automatic memPayload_t refModel(input logic [5:0] func, input logic [3:0] fmt,
                                             input logic [63:0] a, input logic [63:0] b);
        memPayload_t r;
        fpOp_t       cls;
        logic        dbl;
        logic [63:0] src;
        logic [63:0] aw;
        logic [63:0] bw;
        logic [63:0] ka;
        logic [63:0] kb;
        logic        un;
        logic        eq;
        logic        lt;
        int          sp;
        r   = '0;
        dbl = (fmt == FMT_DOUBLE);
        sp  = dbl ? 63 : 31;
        src = dbl ? a : {32'b0, a[31:0]};
        aw  = dbl ? a : {a[31:0], 32'b0};
        bw  = dbl ? b : {b[31:0], 32'b0};
        if (func[5:4] == FN_CMP_HI)
            cls = CMP;
        else if (func == FN_MOV)
            cls = MOV;
        else if (func == FN_ABS)
            cls = ABS;
        else if (func == FN_NEG)
            cls = NEG;
        else
            cls = UNIM;  // Arithmetic, converts and unknown codes alike
        if (fmt != FMT_SINGLE && fmt != FMT_DOUBLE && fmt != FMT_FIXED)
            cls = UNIM;
        case (cls)
            MOV: r.result = src;
            ABS: begin
                r.result     = src;
                r.result[sp] = 1'b0;
            end
            NEG: begin
                r.result     = src;
                r.result[sp] = ~src[sp];
            end
            CMP: begin
                un = isNan(a, dbl) || isNan(b, dbl);
                ka = orderKey(aw);
                kb = orderKey(bw);
                eq = !un && ((aw[62:0] == '0 && bw[62:0] == '0) || ka == kb);
                lt = !un && !eq && (ka < kb);
                r.cond         = (func[0] && un) || (func[1] && eq) || (func[2] && lt);
                r.exc[EXC_INV] = un && func[3];
            end
            default: r.exc[EXC_UNIM] = 1'b1;
        endcase
        return r;
    endfunction

    // Retirement and CSR checker sampled mid-cycle
    always @(negedge phi1) begin : monitor
        memPayload_t want;
        logic [31:0] nextCsr;
        logic        expTrap;
        int          acc;
        if (checking) begin
            checkWord("csr", {32'b0, csr}, {32'b0, csrModel});
            if (stall)
                checkBit("resultValid", resultValid, 1'b0);
            nextCsr = csrWe ? csrWrData : csrModel;
            expTrap = 1'b0;
            if (resultValid) begin
                if (expQ.size() == 0) begin
                    abortRun("A result retired with no instruction outstanding");
                end else begin
                    want = expQ.pop_front();
                    acc  = acceptQ.pop_front();
                    checkWord("result", result, want.result);
                    checkExc("resultExc", resultExc, want.exc);
                    checkBit("fpCond", fpCond, want.cond);
                    if (latencyCheck && (cycleCount - acc != 2))
                        abortRun("A result retired at the wrong cycle");
                    expTrap = want.exc[EXC_UNIM] ||
                              (|(want.exc[EXC_INV:0] & csrModel[CSR_EN_HI:CSR_EN_LO]));
                    nextCsr[CSR_CAUSE_HI:CSR_CAUSE_LO] = want.exc;
                    nextCsr[CSR_FLAGS_HI:CSR_FLAGS_LO] =
                        nextCsr[CSR_FLAGS_HI:CSR_FLAGS_LO] | want.exc[EXC_INV:0];
                    nextCsr[CSR_COND] = want.cond;
                end
            end
            checkBit("fpTrap", fpTrap, expTrap);
            if (fpTrap)
                trapCount++;
            csrModel = nextCsr;
        end
    end

    // Holds the instruction until a cycle without stall takes it
    task automatic sendInstr(input logic [31:0] word, input logic [63:0] a,
                             input logic [63:0] b, input logic randStall);
        logic [31:0] r;
        logic        stallNow;
        instr      = word;
        instrValid = 1'b1;
        opA        = a;
        opB        = b;
        do begin
            r        = $random(seed);
            stallNow = randStall && r[0];
            stall    = stallNow;
            @(posedge phi1);
            #1;
        end while (stallNow);
        checkBit("instrIsFp", instrIsFp, word[31:26] == COP1);
        if (word[31:26] == COP1) begin
            expQ.push_back(refModel(word[5:0], word[24:21], a, b));
            acceptQ.push_back(cycleCount);
        end
        instrValid = 1'b0;
        stall      = 1'b0;
    endtask

    task automatic drain();
        int waitCycles;
        waitCycles = 0;
        while (expQ.size() != 0 && waitCycles < 10) begin
            @(posedge phi1);
            #1;
            waitCycles++;
        end
        if (expQ.size() != 0)
            abortRun("Instructions never retired, results were lost");
        @(posedge phi1);
        #1;
    endtask

    task automatic writeCsr(input logic [31:0] data);
        csrWe     = 1'b1;
        csrWrData = data;
        @(posedge phi1);
        #1;
        csrWe = 1'b0;
    endtask

    task automatic decodeTest();
        logic [5:0] funcs [8];
        logic [3:0] fmts [3];
        logic [7:0] expOps;
        logic [2:0] expFmt;
        funcs = '{FN_ADD, FN_SUB, FN_MUL, FN_DIV, FN_ABS, FN_MOV, FN_NEG, 6'h32};
        fmts  = '{FMT_SINGLE, FMT_DOUBLE, FMT_FIXED};
        for (int f = 0; f < 8; f++) begin
            for (int m = 0; m < 3; m++) begin
                sendInstr(mkInstr(funcs[f], fmts[m]), 64'h0, 64'h0, 1'b0);
                expOps = 8'h80 >> f;  // Same order as funcs
                expFmt = 3'b100 >> m;
                checkWord("opIs enables", {56'b0, opIsAdd, opIsSub, opIsMul, opIsDiv,
                          opIsAbs, opIsMov, opIsNeg, opIsCmp}, {56'b0, expOps});
                checkWord("fmt enables", {61'b0, fmtSingle, fmtDouble, fmtFixed},
                          {61'b0, expFmt});
            end
        end
        sendInstr({6'h23, 20'h0, FN_MOV}, 64'h0, 64'h0, 1'b0);  // Load word opcode
        checkWord("opIs enables", {56'b0, opIsAdd, opIsSub, opIsMul, opIsDiv,
                  opIsAbs, opIsMov, opIsNeg, opIsCmp}, 64'h0);
        checkWord("fmt enables", {61'b0, fmtSingle, fmtDouble, fmtFixed}, 64'h0);
        drain();
    endtask

    task automatic signOpsTest();
        logic [5:0] ops [3];
        ops = '{FN_MOV, FN_ABS, FN_NEG};
        for (int o = 0; o < 3; o++) begin
            for (int k = 0; k < 16; k++) begin
                sendInstr(mkInstr(ops[o], k[0] ? FMT_DOUBLE : FMT_SINGLE),
                          randWord(), randWord(), 1'b0);
            end
        end
        drain();
    endtask

    function automatic logic [63:0] special(input int k, input logic dbl);
        case (k)
            0: return 64'h0;
            1: return dbl ? 64'h8000_0000_0000_0000 : 64'h8000_0000;  // -0
            2: return dbl ? 64'h7ff8_0000_0000_0000 : 64'h7fc0_0000;  // Quiet NaN
            3: return dbl ? 64'h3ff0_0000_0000_0000 : 64'h3f80_0000;
            4: return dbl ? 64'hbff0_0000_0000_0000 : 64'hbf80_0000;
            5: return dbl ? 64'hc000_0000_0000_0000 : 64'hc000_0000;
            default: return randWord();
        endcase
    endfunction

    task automatic compareTest();
        int          pa [7];
        int          pb [7];
        logic [63:0] a;
        logic [63:0] b;
        pa = '{0, 2, 3, 4, 5, 6, 3};
        pb = '{1, 3, 4, 5, 4, 6, 3};
        for (int d = 0; d < 2; d++) begin
            for (int p = 0; p < 7; p++) begin
                a = special(pa[p], d[0]);
                b = special(pb[p], d[0]);
                for (int c = 0; c < 16; c++)
                    sendInstr(mkInstr({FN_CMP_HI, c[3:0]}, d[0] ? FMT_DOUBLE : FMT_SINGLE),
                              a, b, 1'b0);
            end
        end
        drain();
    endtask

    task automatic unimTest();
        int startTraps;
        startTraps = trapCount;
        sendInstr(mkInstr(FN_ADD, FMT_SINGLE), randWord(), randWord(), 1'b0);
        sendInstr(mkInstr(FN_CVTW, FMT_DOUBLE), randWord(), randWord(), 1'b0);
        sendInstr(mkInstr(6'h0f, FMT_SINGLE), randWord(), randWord(), 1'b0);
        drain();
        if (trapCount - startTraps != 3)
            abortRun("Unimplemented operations did not each raise a trap");
        checkExc("csr cause", csr[CSR_CAUSE_HI:CSR_CAUSE_LO], 6'b10_0000);
    endtask

    task automatic stickyTest();
        int startTraps;
        writeCsr(32'h1 << (CSR_EN_LO + EXC_INV));  // Enable invalid only
        startTraps = trapCount;
        sendInstr(mkInstr({FN_CMP_HI, 4'b1001}, FMT_SINGLE), 64'h7fc0_0000, 64'h3f80_0000, 1'b0);
        drain();
        if (trapCount - startTraps != 1)
            abortRun("Signalling compare on a NaN did not trap with invalid enabled");
        checkBit("csr invalid flag", csr[CSR_FLAGS_LO + EXC_INV], 1'b1);
        sendInstr(mkInstr(FN_MOV, FMT_SINGLE), 64'h3f80_0000, 64'h0, 1'b0);
        drain();
        checkBit("csr invalid flag", csr[CSR_FLAGS_LO + EXC_INV], 1'b1);
        checkExc("csr cause", csr[CSR_CAUSE_HI:CSR_CAUSE_LO], 6'b00_0000);
    endtask

    task automatic stallTest();
        logic [31:0] r;
        logic [5:0]  func;
        latencyCheck = 1'b0;  // Stalls stretch the latency
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0: func = FN_ADD;
                3'd1: func = FN_ABS;
                3'd2: func = FN_MOV;
                3'd3: func = FN_NEG;
                3'd4, 3'd5: func = {FN_CMP_HI, r[7:4]};
                3'd6: func = FN_CVTW;
                default: func = 6'h0f;
            endcase
            sendInstr(mkInstr(func, r[8] ? FMT_DOUBLE : FMT_SINGLE),
                      randWord(), randWord(), 1'b1);
        end
        // Keep stalling while the tail drains
        repeat (12) begin
            r     = $random(seed);
            stall = r[0];
            @(posedge phi1);
            #1;
        end
        stall = 1'b0;
        drain();
    endtask

    initial begin
        phi1         = 1'b0;
        arstN        = 1'b0;
        instr        = 32'h0;
        instrValid   = 1'b0;
        opA          = 64'h0;
        opB          = 64'h0;
        stall        = 1'b0;
        csrWe        = 1'b0;
        csrWrData    = 32'h0;
        checking     = 1'b0;
        latencyCheck = 1'b1;
        csrModel     = 32'h0;
        repeat (10) @(posedge phi1);
        #1;
        arstN    = 1'b1;
        checking = 1'b1;
        decodeTest();
        signOpsTest();
        compareTest();
        unimTest();
        stickyTest();
        stallTest();
        $display(">>> PASS");
        $finish;
    end

    initial begin : watchdog
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        abortRun("Timeout, the tests ran past their expected length");
    end

endmodule

`default_nettype wire

// ==== fpCtrlUnit.f ====
design/fpCtrlPkg.sv
design/fpStageReg.sv
design/fpDecode.sv
design/fpExecute.sv
design/fpCsr.sv
design/fpCtrlUnit.sv
sim/fpCtrlUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fpCtrlUnitTb \
    -f fpCtrlUnit.f \
    -o fpCtrlUnitSim

out=$(./obj_dir/fpCtrlUnitSim 2>&1 | tee /dev/stderr)

if grep -qx '>>> PASS' <<< "$out"; then
    exit 0
else
    exit 1
fi
